// ==== filelist.f ====
+incdir+logic
logic/axi_ram_pkg.sv
logic/burst_addr_gen.sv
logic/axi_write_path.sv
logic/axi_read_path.sv
logic/strobe_ram.sv
logic/axi_ram.sv
test/axi_ram_tb.sv

// ==== logic/axi_ram.sv ====
// AXI4 RAM slave; full-width beats only, WLAST ignored, responses always OKAY
`include "axi_ram_macros.svh"

module axi_ram (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  logic [`AXI_ID_W-1:0]   S_AXI_AWID,
    input  logic [`AXI_ADDR_W-1:0] S_AXI_AWADDR,
    input  logic [`AXI_LEN_W-1:0]  S_AXI_AWLEN,
    input  logic [1:0]             S_AXI_AWBURST,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    input  logic [`AXI_DATA_W-1:0] S_AXI_WDATA,
    input  logic [`AXI_STRB_W-1:0] S_AXI_WSTRB,
    input  logic                   S_AXI_WLAST,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    output logic [`AXI_ID_W-1:0]   S_AXI_BID,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,
    input  logic [`AXI_ID_W-1:0]   S_AXI_ARID,
    input  logic [`AXI_ADDR_W-1:0] S_AXI_ARADDR,
    input  logic [`AXI_LEN_W-1:0]  S_AXI_ARLEN,
    input  logic [1:0]             S_AXI_ARBURST,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    output logic [`AXI_ID_W-1:0]   S_AXI_RID,
    output logic [`AXI_DATA_W-1:0] S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RLAST,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY
);

    axi_ram_pkg::burst_cmd_t aw_cmd;
    axi_ram_pkg::burst_cmd_t ar_cmd;
    axi_ram_pkg::r_beat_t    r_beat;
    axi_ram_pkg::resp_e      bresp;
    logic                    ram_we;
    logic [`RAM_AW-1:0]      ram_waddr;
    logic [`AXI_DATA_W-1:0]  ram_wdata;
    logic [`AXI_STRB_W-1:0]  ram_wstrb;
    logic                    ram_re;
    logic [`RAM_AW-1:0]      ram_raddr;
    logic [`AXI_DATA_W-1:0]  ram_rdata;

    // pack request channels
    assign aw_cmd = '{id: S_AXI_AWID, addr: S_AXI_AWADDR, len: S_AXI_AWLEN,
                      burst: axi_ram_pkg::burst_e'(S_AXI_AWBURST)};
    assign ar_cmd = '{id: S_AXI_ARID, addr: S_AXI_ARADDR, len: S_AXI_ARLEN,
                      burst: axi_ram_pkg::burst_e'(S_AXI_ARBURST)};

    axi_write_path u_write_path (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .aw_cmd        (aw_cmd),
        .aw_valid      (S_AXI_AWVALID),
        .aw_ready      (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .w_valid       (S_AXI_WVALID),
        .w_ready       (S_AXI_WREADY),
        .bid           (S_AXI_BID),
        .bresp         (bresp),
        .b_valid       (S_AXI_BVALID),
        .b_ready       (S_AXI_BREADY),
        .ram_we        (ram_we),
        .ram_waddr     (ram_waddr),
        .ram_wdata     (ram_wdata),
        .ram_wstrb     (ram_wstrb)
    );

    axi_read_path u_read_path (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ar_cmd        (ar_cmd),
        .ar_valid      (S_AXI_ARVALID),
        .ar_ready      (S_AXI_ARREADY),
        .r_beat        (r_beat),
        .r_valid       (S_AXI_RVALID),
        .r_ready       (S_AXI_RREADY),
        .ram_re        (ram_re),
        .ram_raddr     (ram_raddr),
        .ram_rdata     (ram_rdata)
    );

    strobe_ram u_ram (
        .S_AXI_ACLK (S_AXI_ACLK),
        .we         (ram_we),
        .waddr      (ram_waddr),
        .wdata      (ram_wdata),
        .wstrb      (ram_wstrb),
        .re         (ram_re),
        .raddr      (ram_raddr),
        .rdata      (ram_rdata)
    );

    // unpack R beat
    assign S_AXI_RID   = r_beat.id;
    assign S_AXI_RDATA = r_beat.data;
    assign S_AXI_RLAST = r_beat.last;
    assign S_AXI_RRESP = axi_ram_pkg::resp_okay;
    assign S_AXI_BRESP = bresp;

endmodule

// ==== logic/axi_ram_macros.svh ====
// widths fixed at build time; RAM_AW must be at least AXI_LEN_W and ADDR_LSB+RAM_AW <= AXI_ADDR_W
`ifndef AXI_RAM_MACROS_SVH
`define AXI_RAM_MACROS_SVH

// AXI ID width, echoed on B and R
`define AXI_ID_W 4

// byte address width of AW and AR
`define AXI_ADDR_W 16

// data bus width, every beat is a full word
`define AXI_DATA_W 32

`define AXI_STRB_W 4 // one strobe per byte lane

// AxLEN field, beats minus one
`define AXI_LEN_W 8

// byte offset bits dropped to get a word address
`define ADDR_LSB 2

// RAM word address width, upper word bits wrap around
`define RAM_AW 10

// R buffer entries, also the limit on beats in flight
`define RBUF_DEPTH 2

`endif

// ==== logic/axi_ram_pkg.sv ====
// shared AXI RAM types; struct widths follow the macros header, only OKAY responses exist
`include "axi_ram_macros.svh"

package axi_ram_pkg;

    // AxBURST codes, reserved code runs as INCR
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10,
        burst_rsvd  = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        resp_okay = 2'b00
    } resp_e;

    // write path FSM
    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_e;

    // one AW or AR request
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;   // byte address
        logic [`AXI_LEN_W-1:0]  len;
        burst_e                 burst;
    } burst_cmd_t;

    // word address of the current beat
    typedef struct packed {
        logic [`RAM_AW-1:0] addr;
        logic               last;
    } beat_addr_t;

    // one R channel beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } r_beat_t;

endpackage

// ==== logic/axi_read_path.sv ====
// one read burst at a time; at most RBUF_DEPTH beats buffered or in flight; RBUF_DEPTH a power of 2
`include "axi_ram_macros.svh"

module axi_read_path (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  axi_ram_pkg::burst_cmd_t  ar_cmd,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    output axi_ram_pkg::r_beat_t     r_beat,
    output logic                     r_valid,
    input  logic                     r_ready,
    output logic                     ram_re,
    output logic [`RAM_AW-1:0]       ram_raddr,
    input  logic [`AXI_DATA_W-1:0]   ram_rdata
);

    localparam int PTR_W = $clog2(`RBUF_DEPTH);
    localparam int CNT_W = $clog2(`RBUF_DEPTH + 1);

    axi_ram_pkg::beat_addr_t beat;
    axi_ram_pkg::r_beat_t    rbuf_q [`RBUF_DEPTH];
    axi_ram_pkg::r_beat_t    push_beat;
    logic                    gen_active;
    logic                    ar_ready_q;
    logic                    start;
    logic                    issue;
    logic                    push;
    logic                    pop;
    logic [CNT_W:0]          committed;
    logic [CNT_W-1:0]        count_q;
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [`AXI_ID_W-1:0]    id_q;
    logic                    infl_valid_q; // RAM read outstanding
    logic                    infl_last_q;
    logic [`AXI_ID_W-1:0]    infl_id_q;

    assign start = ar_valid && ar_ready_q;
    assign push  = infl_valid_q;
    assign pop   = r_valid && r_ready;

    // slots taken after this edge without a new issue
    assign committed = (CNT_W+1)'(count_q) + (CNT_W+1)'(infl_valid_q) - (CNT_W+1)'(pop);
    assign issue     = gen_active && (committed < `RBUF_DEPTH);

    burst_addr_gen u_addr_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (start),
        .cmd           (ar_cmd),
        .step          (issue),
        .beat          (beat),
        .active        (gen_active)
    );

    assign ram_re    = issue;
    assign ram_raddr = beat.addr;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ar_ready_q   <= 1'b0;
            infl_valid_q <= 1'b0;
            count_q      <= '0;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
        end else begin
            // ready again once the generator goes idle
            ar_ready_q   <= !(start || (gen_active && !(issue && beat.last)));
            infl_valid_q <= issue;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    // beat tags and buffer data
    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            id_q <= ar_cmd.id;
        end
        if (issue) begin
            infl_id_q   <= id_q;
            infl_last_q <= beat.last;
        end
        if (push) begin
            rbuf_q[wr_ptr_q] <= push_beat;
        end
    end

    assign push_beat.id   = infl_id_q;
    assign push_beat.data = ram_rdata; // RAM output valid this cycle
    assign push_beat.last = infl_last_q;

    assign ar_ready = ar_ready_q;
    assign r_beat   = rbuf_q[rd_ptr_q];
    assign r_valid  = (count_q != '0);

endmodule

// ==== logic/axi_write_path.sv ====
// one write burst at a time; burst ends by beat count; a stalled B blocks the next AW
`include "axi_ram_macros.svh"

module axi_write_path (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  axi_ram_pkg::burst_cmd_t  aw_cmd,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_STRB_W-1:0]   wstrb,
    input  logic                     w_valid,
    output logic                     w_ready,
    output logic [`AXI_ID_W-1:0]     bid,
    output axi_ram_pkg::resp_e       bresp,
    output logic                     b_valid,
    input  logic                     b_ready,
    output logic                     ram_we,
    output logic [`RAM_AW-1:0]       ram_waddr,
    output logic [`AXI_DATA_W-1:0]   ram_wdata,
    output logic [`AXI_STRB_W-1:0]   ram_wstrb
);

    axi_ram_pkg::wr_state_e  state_q;
    axi_ram_pkg::wr_state_e  state_d;
    axi_ram_pkg::beat_addr_t beat;
    logic                    aw_ready_q;
    logic                    aw_hs;
    logic                    w_hs;
    logic [`AXI_ID_W-1:0]    id_q;

    assign aw_hs = aw_valid && aw_ready_q;
    assign w_hs  = w_valid && w_ready;

    burst_addr_gen u_addr_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (aw_hs),
        .cmd           (aw_cmd),
        .step          (w_hs),
        .beat          (beat),
        .active        ()
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            axi_ram_pkg::wr_idle: begin
                if (aw_hs) begin
                    state_d = axi_ram_pkg::wr_data;
                end
            end
            axi_ram_pkg::wr_data: begin
                if (w_hs && beat.last) begin
                    state_d = axi_ram_pkg::wr_resp;
                end
            end
            axi_ram_pkg::wr_resp: begin
                if (b_ready) begin
                    state_d = axi_ram_pkg::wr_idle; // B accepted
                end
            end
            default: state_d = axi_ram_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state_q    <= axi_ram_pkg::wr_idle;
            aw_ready_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            aw_ready_q <= (state_d == axi_ram_pkg::wr_idle); // tracks wr_idle
        end
    end

    // ID held for the B response
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            id_q <= aw_cmd.id;
        end
    end

    assign aw_ready = aw_ready_q;
    assign w_ready  = (state_q == axi_ram_pkg::wr_data);

    // strobed write lands at the W handshake edge
    assign ram_we    = w_hs;
    assign ram_waddr = beat.addr;
    assign ram_wdata = wdata;
    assign ram_wstrb = wstrb;

    assign b_valid = (state_q == axi_ram_pkg::wr_resp);
    assign bid     = id_q;
    assign bresp   = axi_ram_pkg::resp_okay;

endmodule

// ==== logic/burst_addr_gen.sv ====
// beat address stepper; WRAP needs len of 1, 3, 7 or 15, a start while active reloads the burst
`include "axi_ram_macros.svh"

module burst_addr_gen (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic                    start,
    input  axi_ram_pkg::burst_cmd_t cmd,
    input  logic                    step,
    output axi_ram_pkg::beat_addr_t beat,
    output logic                    active
);

    logic [`RAM_AW-1:0]    start_addr;
    logic [`RAM_AW-1:0]    start_mask;
    logic [`RAM_AW-1:0]    addr_q;
    logic [`RAM_AW-1:0]    next_addr;
    logic [`RAM_AW-1:0]    wrap_base_q;
    logic [`RAM_AW-1:0]    wrap_mask_q;
    logic [`AXI_LEN_W-1:0] cnt_q;
    logic [`AXI_LEN_W-1:0] len_q;
    axi_ram_pkg::burst_e   burst_q;
    logic                  active_q;

    assign start_addr = cmd.addr[`ADDR_LSB +: `RAM_AW]; // high word bits fall off
    assign start_mask = `RAM_AW'(cmd.len);             // len+1 words per wrap block

    // next word by burst rule
    always_comb begin
        case (burst_q)
            axi_ram_pkg::burst_fixed: next_addr = addr_q;
            axi_ram_pkg::burst_wrap:  next_addr = wrap_base_q | ((addr_q + 1'b1) & wrap_mask_q);
            axi_ram_pkg::burst_incr,
            axi_ram_pkg::burst_rsvd:  next_addr = addr_q + 1'b1;
            default:                  next_addr = addr_q + 1'b1;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (start) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (step && active_q) begin
            if (cnt_q == len_q) begin
                active_q <= 1'b0; // last beat consumed
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // burst payload, loaded on start
    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            addr_q      <= start_addr;
            len_q       <= cmd.len;
            burst_q     <= cmd.burst;
            wrap_mask_q <= start_mask;
            wrap_base_q <= start_addr & ~start_mask;
        end else if (step && active_q) begin
            addr_q <= next_addr;
        end
    end

    assign beat.addr = addr_q;
    assign beat.last = (cnt_q == len_q);
    assign active    = active_q;

endmodule

// ==== logic/strobe_ram.sv ====
// word RAM without reset or init, read of a word written in the same cycle returns old data
`include "axi_ram_macros.svh"

module strobe_ram (
    input  logic                   S_AXI_ACLK,
    input  logic                   we,
    input  logic [`RAM_AW-1:0]     waddr,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   re,
    input  logic [`RAM_AW-1:0]     raddr,
    output logic [`AXI_DATA_W-1:0] rdata
);

    logic [`AXI_DATA_W-1:0] mem [2**`RAM_AW];

    always_ff @(posedge S_AXI_ACLK) begin
        if (we) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][8*i +: 8] <= wdata[8*i +: 8]; // byte lane i
                end
            end
        end
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds and runs the AXI RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module axi_ram_tb -f filelist.f \
    --Mdir obj_dir -o axi_ram_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/axi_ram_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== test/axi_ram_tb.sv ====
// one burst at a time in table order; reads only touch words written earlier since the RAM has no init
`include "axi_ram_macros.svh"

module axi_ram_tb;

    localparam int RAM_WORDS = 1 << `RAM_AW;
    localparam int NUM_ROWS  = 15;

    typedef struct {
        string                  name;
        bit                     wr;     // set for a write row
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        axi_ram_pkg::burst_e    burst;
        logic [`AXI_STRB_W-1:0] strb;   // rotated left one lane per beat
    } test_row_t;

    logic                   S_AXI_ACLK    = 1'b0;
    logic                   S_AXI_ARESETN = 1'b0;
    logic [`AXI_ID_W-1:0]   S_AXI_AWID    = '0;
    logic [`AXI_ADDR_W-1:0] S_AXI_AWADDR  = '0;
    logic [`AXI_LEN_W-1:0]  S_AXI_AWLEN   = '0;
    logic [1:0]             S_AXI_AWBURST = '0;
    logic                   S_AXI_AWVALID = 1'b0;
    logic                   S_AXI_AWREADY;
    logic [`AXI_DATA_W-1:0] S_AXI_WDATA   = '0;
    logic [`AXI_STRB_W-1:0] S_AXI_WSTRB   = '0;
    logic                   S_AXI_WLAST   = 1'b0;
    logic                   S_AXI_WVALID  = 1'b0;
    logic                   S_AXI_WREADY;
    logic [`AXI_ID_W-1:0]   S_AXI_BID;
    logic [1:0]             S_AXI_BRESP;
    logic                   S_AXI_BVALID;
    logic                   S_AXI_BREADY  = 1'b0;
    logic [`AXI_ID_W-1:0]   S_AXI_ARID    = '0;
    logic [`AXI_ADDR_W-1:0] S_AXI_ARADDR  = '0;
    logic [`AXI_LEN_W-1:0]  S_AXI_ARLEN   = '0;
    logic [1:0]             S_AXI_ARBURST = '0;
    logic                   S_AXI_ARVALID = 1'b0;
    logic                   S_AXI_ARREADY;
    logic [`AXI_ID_W-1:0]   S_AXI_RID;
    logic [`AXI_DATA_W-1:0] S_AXI_RDATA;
    logic [1:0]             S_AXI_RRESP;
    logic                   S_AXI_RLAST;
    logic                   S_AXI_RVALID;
    logic                   S_AXI_RREADY  = 1'b0;

    test_row_t              rows [NUM_ROWS];
    logic [`AXI_DATA_W-1:0] model_mem [RAM_WORDS]; // reference copy of the RAM
    string                  cur_name;
    int                     row_errs;
    int                     total_errs;
    int                     failed_rows;
    int                     tests_run;
    int                     limit;

    axi_ram u_axi_ram (.*);

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;

    // random back-pressure with ready about three cycles in four
    always @(posedge S_AXI_ACLK) begin
        S_AXI_RREADY <= ($urandom_range(3) != 0);
        S_AXI_BREADY <= ($urandom_range(3) != 0);
    end

    task automatic load_table();
        rows[0]  = '{"incr_wr8",  1'b1, 4'h3, 16'h0040, 8'd7,  axi_ram_pkg::burst_incr,  4'hf};
        rows[1]  = '{"incr_rd8",  1'b0, 4'h5, 16'h0040, 8'd7,  axi_ram_pkg::burst_incr,  4'h0};
        rows[2]  = '{"wrap_wr4",  1'b1, 4'h1, 16'h0108, 8'd3,  axi_ram_pkg::burst_wrap,  4'hf};
        rows[3]  = '{"wrap_chk",  1'b0, 4'h2, 16'h0100, 8'd3,  axi_ram_pkg::burst_incr,  4'h0};
        rows[4]  = '{"fixed_wr4", 1'b1, 4'h6, 16'h0200, 8'd3,  axi_ram_pkg::burst_fixed, 4'hf};
        rows[5]  = '{"fixed_rd4", 1'b0, 4'h7, 16'h0200, 8'd3,  axi_ram_pkg::burst_fixed, 4'h0};
        rows[6]  = '{"strb_wr8",  1'b1, 4'h8, 16'h0040, 8'd7,  axi_ram_pkg::burst_incr,  4'h5};
        rows[7]  = '{"strb_chk",  1'b0, 4'h9, 16'h0040, 8'd7,  axi_ram_pkg::burst_incr,  4'h0};
        rows[8]  = '{"rsvd_wr16", 1'b1, 4'ha, 16'h0300, 8'd15, axi_ram_pkg::burst_rsvd,  4'hf};
        rows[9]  = '{"wrap_wr8",  1'b1, 4'hb, 16'h0314, 8'd7,  axi_ram_pkg::burst_wrap,  4'h3};
        rows[10] = '{"wrap_rd16", 1'b0, 4'hc, 16'h0320, 8'd15, axi_ram_pkg::burst_wrap,  4'h0};
        rows[11] = '{"rsvd_rd16", 1'b0, 4'hd, 16'h0300, 8'd15, axi_ram_pkg::burst_rsvd,  4'h0};
        rows[12] = '{"wrap_rd2",  1'b0, 4'he, 16'h0304, 8'd1,  axi_ram_pkg::burst_wrap,  4'h0};
        rows[13] = '{"alias_wr",  1'b1, 4'hf, 16'hfff8, 8'd3,  axi_ram_pkg::burst_incr,  4'hf};
        rows[14] = '{"alias_rd",  1'b0, 4'h0, 16'h0ff8, 8'd3,  axi_ram_pkg::burst_incr,  4'h0};
    endtask

    // word of one beat by the AXI burst rules
    function automatic int beat_word(input test_row_t row, input int beat);
        int first;
        int span;
        first = int'(row.addr[`ADDR_LSB +: `RAM_AW]); // upper word bits alias
        span  = int'(row.len) + 1;
        case (row.burst)
            axi_ram_pkg::burst_fixed: return first;
            axi_ram_pkg::burst_wrap:  return (first / span) * span + (first % span + beat) % span;
            default:                  return (first + beat) % RAM_WORDS;
        endcase
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] merge_bytes(input logic [`AXI_DATA_W-1:0] old,
            input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
        logic [`AXI_DATA_W-1:0] merged;
        merged = old;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [`AXI_STRB_W-1:0] rotate_strobe(input logic [`AXI_STRB_W-1:0] strb,
            input int beat);
        logic [2*`AXI_STRB_W-1:0] twice;
        twice = {strb, strb} << (beat % `AXI_STRB_W);
        return twice[2*`AXI_STRB_W-1 -: `AXI_STRB_W];
    endfunction

    task automatic check_field(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("error %s %s expected %0h actual %0h", cur_name, what, exp, act);
            row_errs++;
        end
    endtask

    task automatic report_row();
        tests_run++;
        total_errs += row_errs;
        if (row_errs == 0) begin
            $display("%s passed", cur_name);
        end else begin
            failed_rows++;
            $display("%s failed with %0d mismatches", cur_name, row_errs);
        end
    endtask

    task automatic run_write(input test_row_t row);
        int                     beats;
        int                     w;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        beats = int'(row.len) + 1;
        S_AXI_AWID    <= row.id;
        S_AXI_AWADDR  <= row.addr;
        S_AXI_AWLEN   <= row.len;
        S_AXI_AWBURST <= row.burst;
        S_AXI_AWVALID <= 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!S_AXI_AWREADY);
        S_AXI_AWVALID <= 1'b0;
        for (int b = 0; b < beats; b++) begin
            data = $urandom();
            strb = rotate_strobe(row.strb, b);
            S_AXI_WDATA  <= data;
            S_AXI_WSTRB  <= strb;
            S_AXI_WLAST  <= (b == beats - 1);
            S_AXI_WVALID <= 1'b1;
            do begin
                @(posedge S_AXI_ACLK);
            end while (!S_AXI_WREADY);
            w = beat_word(row, b);
            model_mem[w] = merge_bytes(model_mem[w], data, strb); // beat taken at this edge
        end
        S_AXI_WVALID <= 1'b0;
        S_AXI_WLAST  <= 1'b0;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!(S_AXI_BVALID && S_AXI_BREADY));
        check_field("bid", 64'(row.id), 64'(S_AXI_BID));
        check_field("bresp", 64'(axi_ram_pkg::resp_okay), 64'(S_AXI_BRESP));
    endtask

    task automatic run_read(input test_row_t row);
        int          beats;
        int          b;
        bit          held_valid;
        logic [63:0] held;
        logic [63:0] r_now;
        beats      = int'(row.len) + 1;
        b          = 0;
        held_valid = 1'b0;
        held       = '0;
        S_AXI_ARID    <= row.id;
        S_AXI_ARADDR  <= row.addr;
        S_AXI_ARLEN   <= row.len;
        S_AXI_ARBURST <= row.burst;
        S_AXI_ARVALID <= 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!S_AXI_ARREADY);
        S_AXI_ARVALID <= 1'b0;
        while (b < beats) begin
            @(posedge S_AXI_ACLK);
            r_now = 64'({S_AXI_RVALID, S_AXI_RID, S_AXI_RDATA, S_AXI_RLAST});
            if (held_valid) begin
                check_field("stalled R beat", held, r_now); // must not move while RREADY low
            end
            held_valid = S_AXI_RVALID && !S_AXI_RREADY;
            held       = r_now;
            if (S_AXI_RVALID && S_AXI_RREADY) begin
                check_field("rdata", 64'(model_mem[beat_word(row, b)]), 64'(S_AXI_RDATA));
                check_field("rid", 64'(row.id), 64'(S_AXI_RID));
                check_field("rlast", 64'(b == beats - 1), 64'(S_AXI_RLAST));
                check_field("rresp", 64'(axi_ram_pkg::resp_okay), 64'(S_AXI_RRESP));
                b++;
            end
        end
        @(posedge S_AXI_ACLK);
        assert (!S_AXI_RVALID) else begin
            $display("%s: R channel still valid after the beat with RLAST", cur_name);
            row_errs++;
        end
    endtask

    initial begin
        void'($urandom(17875));
        load_table();
        limit = 500;
        foreach (rows[i]) begin
            limit += (int'(rows[i].len) + 1) * 20;
        end
        fork
            begin
                repeat (limit) @(posedge S_AXI_ACLK);
                $display("timeout, the run did not finish within %0d cycles", limit);
                $display("Errors found");
                $finish;
            end
        join_none
        repeat (2) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge S_AXI_ACLK);
        cur_name = "after_reset";
        row_errs = 0;
        check_field("bvalid", 64'(0), 64'(S_AXI_BVALID));
        check_field("rvalid", 64'(0), 64'(S_AXI_RVALID));
        check_field("awready", 64'(0), 64'(S_AXI_AWREADY));
        check_field("wready", 64'(0), 64'(S_AXI_WREADY));
        check_field("arready", 64'(0), 64'(S_AXI_ARREADY));
        report_row();
        foreach (rows[i]) begin
            cur_name = rows[i].name;
            row_errs = 0;
            if (rows[i].wr) begin
                run_write(rows[i]);
            end else begin
                run_read(rows[i]);
            end
            report_row();
        end
        $display("%0d tests, %0d failed, %0d mismatches", tests_run, failed_rows, total_errs);
        if (total_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
